// File: verilog/tag_store_pkg.sv
// Shared widths, request/response structs and enums for the tag store; imported by every module
package tag_store_pkg;

  // Cache geometry
  localparam int unsigned NumWays    = 4;
  localparam int unsigned IndexWidth = 4;
  localparam int unsigned TagWidth   = 8;

  // One bit per way
  typedef logic [NumWays-1:0]         way_onehot_t;
  // Binary way number
  typedef logic [$clog2(NumWays)-1:0] way_bin_t;
  typedef logic [IndexWidth-1:0]      index_t;
  typedef logic [TagWidth-1:0]        tag_t;

  // Request kinds
  typedef enum logic {
    mode_lookup,
    mode_flush
  } tag_mode_e;

  // Line as held in a way memory
  typedef struct packed {
    logic val;
    logic dit;
    tag_t tag;
  } tag_entry_t;

  // Incoming request, way only matters for a flush
  typedef struct packed {
    tag_mode_e mode;
    index_t    index;
    tag_t      tag;
    logic      dirty;
    way_bin_t  way;
  } tag_req_t;

  // Outgoing response
  typedef struct packed {
    way_onehot_t indicator;
    logic        hit;
    logic        evict;
    tag_t        evict_tag;
  } tag_res_t;

  // Controller sequence
  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_respond,
    st_write
  } ctrl_state_e;

endpackage

// File: verilog/tag_way_ram.sv
// Single-port tag memory for one way with a configurable read pipeline; one per way in the top
`timescale 1ns/1ps

module tag_way_ram import tag_store_pkg::*; #(
  parameter int unsigned ReadLatency = 1
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       req_i,
  input  logic       we_i,
  input  index_t     index_i,
  input  tag_entry_t wdata_i,
  output tag_entry_t rdata_o,
  output logic       rvalid_o
);

  localparam int unsigned NumSets = 2 ** IndexWidth;

  tag_entry_t                   mem_q [NumSets];
  // Read token and data pipeline
  logic       [ReadLatency-1:0] rv_q;
  tag_entry_t                   rd_q  [ReadLatency];
  logic                         rd_en;

  assign rd_en = req_i && !we_i;

  // Reset clears every set, writes land on the next edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < NumSets; s++) begin
        mem_q[s] <= tag_entry_t'('0);
      end
    end else if (req_i && we_i) begin
      mem_q[index_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rv_q <= '0;
    end else begin
      rv_q[0] <= rd_en;
      for (int i = 1; i < ReadLatency; i++) begin
        rv_q[i] <= rv_q[i-1];
      end
    end
  end

  // Data shifts along with the token
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rd_q[0] <= mem_q[index_i];
    end
    for (int i = 1; i < ReadLatency; i++) begin
      rd_q[i] <= rd_q[i-1];
    end
  end

  assign rdata_o  = rd_q[ReadLatency-1];
  assign rvalid_o = rv_q[ReadLatency-1];

  // Controller must wait for the read to drain before writing
  a_no_wr_in_flight: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_i && we_i) |-> (rv_q == '0))
    else $error("write issued while a read is still in flight");

endmodule

// File: verilog/tag_victim_select.sv
// Replacement way choice for a lookup miss: first invalid way, else round-robin pointer
`timescale 1ns/1ps

module tag_victim_select import tag_store_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  way_onehot_t tag_valid_i,
  input  logic        take_i,
  output way_onehot_t victim_o
);

  // Rotating pointer for a full set
  way_bin_t    ptr_q;
  way_onehot_t invalid;
  way_onehot_t first_inv;
  logic        set_full;

  assign invalid  = ~tag_valid_i;
  assign set_full = &tag_valid_i;

  // Isolate lowest set bit
  assign first_inv = invalid & (~invalid + way_onehot_t'(1));

  // Zero latency path to the controller
  always_comb begin
    if (set_full) begin
      victim_o = way_onehot_t'(1) << ptr_q;
    end else begin
      victim_o = first_inv;
    end
  end

  // Pointer steps only when it actually picked the victim
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (take_i && set_full) begin
      // Wraps after the last way
      ptr_q <= ptr_q + way_bin_t'(1);
    end
  end

  // Exactly one way for every valid pattern
  a_victim_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    take_i |-> $onehot(victim_o))
    else $error("victim way not one-hot");

endmodule

// File: verilog/tag_res_reg.sv
// Response output stage: two-slot spill register, or a straight path when spilling is off
`timescale 1ns/1ps

module tag_res_reg import tag_store_pkg::*; #(
  parameter bit SpillRes = 1'b1
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  tag_res_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output tag_res_t data_o
);

  if (SpillRes) begin : gen_spill
    // Slot a takes input, slot b holds overflow under back-pressure
    logic     a_full_q;
    logic     b_full_q;
    tag_res_t a_data_q;
    tag_res_t b_data_q;
    logic     a_fill;
    logic     a_drain;
    logic     b_fill;
    logic     b_drain;

    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Ready no longer depends on ready_i
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    // Older entry sits in b
    assign data_o  = b_full_q ? b_data_q : a_data_q;
  end else begin : gen_bypass
    assign ready_o = ready_i;
    assign valid_o = valid_i;
    assign data_o  = data_i;
  end

  // Downstream sees a stable response until it takes it
  a_hold_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)))
    else $error("response dropped or changed under back-pressure");

endmodule

// File: verilog/tag_req_ctrl.sv
// Request FSM of the tag store: reads the set, builds the response and writes the line back
`timescale 1ns/1ps

module tag_req_ctrl import tag_store_pkg::*; (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  tag_req_t                 req_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  output way_onehot_t              ram_req_o,
  output way_onehot_t              ram_we_o,
  output index_t                   ram_index_o,
  output tag_entry_t               ram_wdata_o,
  input  tag_entry_t [NumWays-1:0] ram_rdata_i,
  input  way_onehot_t              ram_rvalid_i,
  output way_onehot_t              tag_valid_o,
  input  way_onehot_t              victim_i,
  output logic                     victim_take_o,
  output tag_res_t                 res_o,
  output logic                     res_valid_o,
  input  logic                     res_ready_i
);

  ctrl_state_e              state_q;
  tag_req_t                 req_q;
  // Read already sent in this st_read visit
  logic                     rd_issued_q;
  tag_entry_t [NumWays-1:0] rdata_q;
  // Ways to write in st_write, zero when nothing to write
  way_onehot_t              wr_way_q;

  way_onehot_t flush_oh;
  way_onehot_t hit;
  way_onehot_t ind;
  logic        is_flush;
  logic        hit_any;
  logic        res_xfer;
  logic        wr_need;
  tag_entry_t  sel_entry;

  assign is_flush = (req_q.mode == mode_flush);
  assign flush_oh = way_onehot_t'(1) << req_q.way;

  // Tag compare on the captured set
  always_comb begin
    for (int i = 0; i < NumWays; i++) begin
      hit[i]         = rdata_q[i].val && (rdata_q[i].tag == req_q.tag);
      tag_valid_o[i] = rdata_q[i].val;
    end
  end

  // A flush never reports a hit
  assign hit_any = !is_flush && (|hit);
  assign ind     = is_flush ? flush_oh : (hit_any ? hit : victim_i);

  // Entry of the selected way; ind is one-hot here
  always_comb begin
    sel_entry = tag_entry_t'('0);
    for (int i = 0; i < NumWays; i++) begin
      if (ind[i]) begin
        sel_entry = rdata_q[i];
      end
    end
  end

  always_comb begin
    res_o           = tag_res_t'('0);
    res_o.indicator = ind;
    res_o.hit       = hit_any;
    // Victim or flushed line goes out only when valid and dirty
    res_o.evict     = !hit_any && sel_entry.val && sel_entry.dit;
    res_o.evict_tag = hit_any ? tag_t'('0) : sel_entry.tag;
  end

  assign ready_o       = (state_q == st_idle);
  assign res_valid_o   = (state_q == st_respond);
  assign res_xfer      = res_valid_o && res_ready_i;
  // Miss consumes the victim, selector steps its pointer
  assign victim_take_o = res_xfer && !is_flush && !hit_any;
  // Clean hit with clean request needs no write
  assign wr_need       = is_flush || !hit_any || (req_q.dirty && !sel_entry.dit);

  // Memory strobes
  always_comb begin
    ram_req_o = '0;
    ram_we_o  = '0;
    if ((state_q == st_read) && !rd_issued_q) begin
      ram_req_o = is_flush ? flush_oh : {NumWays{1'b1}};
    end else if (state_q == st_write) begin
      ram_req_o = wr_way_q;
      ram_we_o  = wr_way_q;
    end
  end

  assign ram_index_o = req_q.index;
  // Flush clears the line, lookup installs or upgrades it
  assign ram_wdata_o = is_flush ? tag_entry_t'('0) :
                       tag_entry_t'{val: 1'b1, dit: req_q.dirty, tag: req_q.tag};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= st_idle;
      rd_issued_q <= 1'b0;
      wr_way_q    <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (valid_i) begin
            state_q <= st_read;
          end
        end
        st_read: begin
          rd_issued_q <= 1'b1;
          // All read ways return together
          if (|ram_rvalid_i) begin
            state_q     <= st_respond;
            rd_issued_q <= 1'b0;
          end
        end
        st_respond: begin
          // Latch the way now, victim pointer moves on this edge
          if (res_ready_i) begin
            wr_way_q <= wr_need ? ind : way_onehot_t'('0);
            state_q  <= st_write;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // Request and read data hold
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      req_q <= req_i;
    end
    for (int i = 0; i < NumWays; i++) begin
      if (ram_rvalid_i[i]) begin
        rdata_q[i] <= ram_rdata_i[i];
      end
    end
  end

  // Victim from the selector must combine with hits into a single way
  a_res_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    res_valid_o |-> $onehot(res_o.indicator))
    else $error("response indicator not one-hot");

endmodule

// File: verilog/tag_store_top.sv
// Tag store top level: controller, four way memories, victim selector and response register
`timescale 1ns/1ps

module tag_store_top import tag_store_pkg::*; #(
  parameter int unsigned ReadLatency = 1,
  parameter bit          SpillRes    = 1'b1
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  tag_req_t req_i,
  input  logic     valid_i,
  output logic     ready_o,
  output tag_res_t res_o,
  output logic     valid_o,
  input  logic     ready_i
);

  // Controller to memories
  way_onehot_t              ram_req;
  way_onehot_t              ram_we;
  index_t                   ram_index;
  tag_entry_t               ram_wdata;
  tag_entry_t [NumWays-1:0] ram_rdata;
  way_onehot_t              ram_rvalid;

  // Controller to victim selector
  way_onehot_t tag_valid;
  way_onehot_t victim;
  logic        victim_take;

  // Controller to response register
  tag_res_t res;
  logic     res_valid;
  logic     res_ready;

  tag_req_ctrl u_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .valid_i       (valid_i),
    .ready_o       (ready_o),
    .ram_req_o     (ram_req),
    .ram_we_o      (ram_we),
    .ram_index_o   (ram_index),
    .ram_wdata_o   (ram_wdata),
    .ram_rdata_i   (ram_rdata),
    .ram_rvalid_i  (ram_rvalid),
    .tag_valid_o   (tag_valid),
    .victim_i      (victim),
    .victim_take_o (victim_take),
    .res_o         (res),
    .res_valid_o   (res_valid),
    .res_ready_i   (res_ready)
  );

  // One memory per way, index and write data shared
  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    tag_way_ram #(
      .ReadLatency (ReadLatency)
    ) u_way_ram (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_i    (ram_req[w]),
      .we_i     (ram_we[w]),
      .index_i  (ram_index),
      .wdata_i  (ram_wdata),
      .rdata_o  (ram_rdata[w]),
      .rvalid_o (ram_rvalid[w])
    );
  end

  tag_victim_select u_victim (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .tag_valid_i (tag_valid),
    .take_i      (victim_take),
    .victim_o    (victim)
  );

  tag_res_reg #(
    .SpillRes (SpillRes)
  ) u_res_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (res_valid),
    .ready_o (res_ready),
    .data_i  (res),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (res_o)
  );

endmodule

// File: sim/tag_store_tb.sv
// Self-checking testbench that runs directed and random tag store requests against a model
`timescale 1ns/1ps

module tag_store_tb import tag_store_pkg::*; ();

  // Directed requests plus the random run
  localparam int NumReqs    = 313;
  localparam int CycleLimit = 40 * NumReqs + 200;
  localparam int NumSets    = 2 ** IndexWidth;

  logic     clk_i;
  logic     reset_i;
  tag_req_t req_i;
  logic     valid_i;
  logic     ready_o;
  tag_res_t res_o;
  logic     valid_o;
  logic     ready_i;

  // Reference tag array and replacement pointer
  tag_entry_t model_mem [NumWays][NumSets];
  way_bin_t   model_ptr;
  tag_res_t   exp_q [$];
  tag_res_t   exp_res;

  int          mismatch_cnt;
  int          extra_cnt;
  int          resp_cnt;
  int          cycles;
  logic        rand_bp;
  logic [31:0] rdy_state;

  tag_store_top dut0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .res_o   (res_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Applies the lookup and flush rules and updates the model
  function automatic tag_res_t predict_res(input tag_req_t r);
    tag_res_t res;
    int       hit_way;
    int       vic;
    res     = '0;
    hit_way = -1;
    vic     = -1;
    if (r.mode == mode_flush) begin
      res.indicator = way_onehot_t'(1) << r.way;
      res.evict     = model_mem[r.way][r.index].val && model_mem[r.way][r.index].dit;
      res.evict_tag = model_mem[r.way][r.index].tag;
      model_mem[r.way][r.index] = '0;
    end else begin
      for (int w = 0; w < NumWays; w++) begin
        if (model_mem[w][r.index].val && model_mem[w][r.index].tag == r.tag) begin
          hit_way = w;
        end
      end
      if (hit_way >= 0) begin
        res.indicator = way_onehot_t'(1) << hit_way;
        res.hit       = 1'b1;
        // Dirty request upgrades a clean line
        if (r.dirty) begin
          model_mem[hit_way][r.index].dit = 1'b1;
        end
      end else begin
        // Lowest invalid way first
        for (int w = NumWays - 1; w >= 0; w--) begin
          if (!model_mem[w][r.index].val) begin
            vic = w;
          end
        end
        if (vic < 0) begin
          vic       = model_ptr;
          model_ptr = model_ptr + way_bin_t'(1);
        end
        res.indicator = way_onehot_t'(1) << vic;
        res.evict     = model_mem[vic][r.index].val && model_mem[vic][r.index].dit;
        res.evict_tag = model_mem[vic][r.index].tag;
        model_mem[vic][r.index] = tag_entry_t'{val: 1'b1, dit: r.dirty, tag: r.tag};
      end
    end
    return res;
  endfunction

  // Holds the request until accepted and then queues the prediction
  task automatic send_req(input tag_req_t r);
    req_i   = r;
    valid_i = 1'b1;
    @(posedge clk_i);
    while (!ready_o) begin
      @(posedge clk_i);
    end
    exp_q.push_back(predict_res(r));
    #2;
    valid_i = 1'b0;
  endtask

  task automatic issue_fields(input tag_mode_e m, input int idx, input int tg,
                              input logic d, input int w);
    tag_req_t r;
    r.mode  = m;
    r.index = index_t'(idx);
    r.tag   = tag_t'(tg);
    r.dirty = d;
    r.way   = way_bin_t'(w);
    send_req(r);
  endtask

  // Response side back-pressure
  always @(posedge clk_i) begin
    #2;
    if (rand_bp) begin
      rdy_state = lcg_next(rdy_state);
      ready_i   = rdy_state[31] & rdy_state[29];
    end else begin
      ready_i = 1'b1;
    end
  end

  // Comparator popping one expected entry per response transfer
  always @(posedge clk_i) begin
    if (!reset_i && valid_o && ready_i) begin
      resp_cnt = resp_cnt + 1;
      if (exp_q.size() == 0) begin
        extra_cnt = extra_cnt + 1;
        $display("unexpected response at %0t ns with no request outstanding", $time);
      end else begin
        exp_res = exp_q.pop_front();
        if (res_o !== exp_res) begin
          mismatch_cnt = mismatch_cnt + 1;
          $display("error at %0t ns: got ind/hit/evict/tag %b/%b/%b/%h, expected %b/%b/%b/%h",
                   $time, res_o.indicator, res_o.hit, res_o.evict, res_o.evict_tag,
                   exp_res.indicator, exp_res.hit, exp_res.evict, exp_res.evict_tag);
        end
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("run timed out after %0d cycles with %0d responses pending", cycles, exp_q.size());
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] st;
    tag_req_t    rnd;
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    req_i        = '0;
    valid_i      = 1'b0;
    ready_i      = 1'b1;
    rand_bp      = 1'b0;
    mismatch_cnt = 0;
    extra_cnt    = 0;
    resp_cnt     = 0;
    cycles       = 0;
    model_ptr    = '0;
    st           = 32'hc1903b82;
    rdy_state    = lcg_next(32'hc1903b82);
    for (int w = 0; w < NumWays; w++) begin
      for (int s = 0; s < NumSets; s++) begin
        model_mem[w][s] = '0;
      end
    end
    repeat (10) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    // First lookup misses into way 0 and then hits, followed by dirty upgrade and flush
    issue_fields(mode_lookup, 3, 'h2a, 1'b0, 0);
    issue_fields(mode_lookup, 3, 'h2a, 1'b0, 0);
    issue_fields(mode_lookup, 3, 'h2a, 1'b1, 0);
    issue_fields(mode_flush, 3, 'h00, 1'b0, 0);

    // Five tags in set 5 where the fifth miss uses the pointer way
    for (int i = 0; i < 5; i++) begin
      issue_fields(mode_lookup, 5, 'h10 + i, logic'(i % 2 == 0), 0);
    end

    // Flushed way becomes the victim again
    issue_fields(mode_lookup, 7, 'h33, 1'b1, 0);
    issue_fields(mode_lookup, 7, 'h44, 1'b0, 0);
    issue_fields(mode_flush, 7, 'h00, 1'b0, 0);
    issue_fields(mode_lookup, 7, 'h33, 1'b0, 0);

    // Random mix over two sets and eight tags
    rand_bp = 1'b1;
    for (int n = 0; n < 300; n++) begin
      st        = lcg_next(st);
      rnd.mode  = (st[31:30] == 2'b00) ? mode_flush : mode_lookup;
      rnd.index = index_t'(st[29]);
      rnd.tag   = tag_t'(st[27:25]);
      rnd.dirty = st[24];
      rnd.way   = way_bin_t'(st[23:22]);
      send_req(rnd);
    end
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    rand_bp = 1'b0;
    repeat (5) @(posedge clk_i);

    $display("%0d responses, %0d mismatches, %0d unexpected responses",
             resp_cnt, mismatch_cnt, extra_cnt);
    if (mismatch_cnt == 0 && extra_cnt == 0 && resp_cnt == NumReqs) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: flist.f
verilog/tag_store_pkg.sv
verilog/tag_way_ram.sv
verilog/tag_victim_select.sv
verilog/tag_res_reg.sv
verilog/tag_req_ctrl.sv
verilog/tag_store_top.sv
sim/tag_store_tb.sv
